/* include/fb_defs.svh */
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// video geometry, tiny for simulation
`define FB_H_ACTIVE 16
`define FB_H_FRONT 8
`define FB_H_SYNC 16
`define FB_H_BACK 176
`define FB_V_ACTIVE 8
`define FB_V_FRONT 1
`define FB_V_SYNC 2
`define FB_V_BACK 2

// sdram timing in clk cycles
`define FB_INIT_WAIT 20
`define FB_REFRESH_INTERVAL 200
`define FB_TRCD 2
`define FB_TRP 2
`define FB_TRFC 3

// request slots per arbiter client
`define FB_CREDITS 2

`endif

/* verilog/sdram_pkg.sv */
package sdram_pkg;

  // {cs, ras, cas, we}
  typedef enum logic [3:0] {
    CMD_NOP       = 4'b0111,
    CMD_ACTIVE    = 4'b0011,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001,
    CMD_LOAD_MODE = 4'b0000
  } sdram_cmd_e;

  typedef enum logic [3:0] {
    ST_INIT,
    ST_PRE_ALL,
    ST_INIT_REF,
    ST_MODE,
    ST_IDLE,
    ST_RCD,
    ST_RW,
    ST_CAS,
    ST_TRP,
    ST_REFRESH
  } ctrl_state_e;

  typedef struct packed {
    logic        wr;
    logic [12:0] row;
    logic [8:0]  col;
    logic [7:0]  data;
  } mem_req_t;

  typedef struct packed {
    logic [7:0] data;
  } mem_rsp_t;

endpackage

/* verilog/video_pkg.sv */
package video_pkg;

  // one bit per colour, low bits of an sdram byte
  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } pixel_t;

  typedef struct packed {
    logic [3:0] x;
    logic [2:0] y;
    pixel_t     pix;
  } host_wr_t;

endpackage

/* verilog/sdram_arbiter.sv */
`include "fb_defs.svh"

module req_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  sdram_pkg::mem_req_t din,
  input  logic                push,
  input  logic                pop,
  output sdram_pkg::mem_req_t dout,
  output logic                not_empty
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  sdram_pkg::mem_req_t mem [DEPTH];
  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;
  logic [AW:0]   count;

  assign dout      = mem[rptr];
  assign not_empty = (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      count <= count + (AW+1)'(push) - (AW+1)'(pop);
    end
  end

  // a push into a full fifo means a client spent a credit it did not hold
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < (AW+1)'(DEPTH)) || pop);

endmodule

module sdram_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  sdram_pkg::mem_req_t wr_req,
  input  logic                wr_req_valid,
  output logic                wr_credit,
  input  sdram_pkg::mem_req_t rd_req,
  input  logic                rd_req_valid,
  output logic                rd_credit,
  output sdram_pkg::mem_req_t ctrl_req,
  output logic                ctrl_req_valid,
  input  logic                ctrl_ready
);
  sdram_pkg::mem_req_t wr_head;
  sdram_pkg::mem_req_t rd_head;
  logic wr_ne;
  logic rd_ne;
  logic pop_wr;
  logic pop_rd;

  req_fifo #(.DEPTH(`FB_CREDITS)) i_wr_fifo (
    .clk(clk), .rst_n(rst_n), .din(wr_req), .push(wr_req_valid),
    .pop(pop_wr), .dout(wr_head), .not_empty(wr_ne)
  );

  req_fifo #(.DEPTH(`FB_CREDITS)) i_rd_fifo (
    .clk(clk), .rst_n(rst_n), .din(rd_req), .push(rd_req_valid),
    .pop(pop_rd), .dout(rd_head), .not_empty(rd_ne)
  );

  // scan-out always wins
  assign ctrl_req       = rd_ne ? rd_head : wr_head;
  assign ctrl_req_valid = rd_ne | wr_ne;
  assign pop_rd         = ctrl_ready & rd_ne;
  assign pop_wr         = ctrl_ready & ~rd_ne & wr_ne;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_credit <= 1'b0;
      rd_credit <= 1'b0;
    end else begin
      wr_credit <= pop_wr;
      rd_credit <= pop_rd;
    end
  end

endmodule

/* verilog/sdram_ctrl.sv */
`include "fb_defs.svh"

module sdram_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  sdram_pkg::mem_req_t ctrl_req,
  input  logic                ctrl_req_valid,
  output logic                ctrl_ready,
  output sdram_pkg::mem_rsp_t rsp,
  output logic                rsp_valid,
  output logic                sdram_clk,
  output logic                sdram_cle,
  output logic                sdram_dqm,
  output logic                sdram_cs,
  output logic                sdram_we,
  output logic                sdram_cas,
  output logic                sdram_ras,
  output logic [1:0]          sdram_ba,
  output logic [12:0]         sdram_a,
  inout  wire  [7:0]          sdram_dq
);
  // burst length 1, sequential, cas latency 2
  localparam logic [12:0] MODE_REG = 13'h020;

  sdram_pkg::ctrl_state_e state;
  sdram_pkg::sdram_cmd_e  cmd_q;
  sdram_pkg::mem_req_t    req_q;
  logic [7:0]  cnt;
  logic [15:0] ref_timer;
  logic        ref_due;
  logic        second_ref;
  logic        dq_oe;
  logic [7:0]  dq_out;
  logic [7:0]  gap;

  assign ref_due    = (ref_timer >= 16'(`FB_REFRESH_INTERVAL));
  assign ctrl_ready = (state == sdram_pkg::ST_IDLE) && !ref_due;

  assign sdram_clk = clk;
  assign sdram_dqm = 1'b0;
  assign sdram_ba  = 2'b00;
  assign {sdram_cs, sdram_ras, sdram_cas, sdram_we} = cmd_q;
  assign sdram_dq  = dq_oe ? dq_out : 8'bz;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= sdram_pkg::ST_INIT;
      cmd_q      <= sdram_pkg::CMD_NOP;
      cnt        <= 8'(`FB_INIT_WAIT - 1);
      ref_timer  <= '0;
      second_ref <= 1'b0;
      dq_oe      <= 1'b0;
      rsp_valid  <= 1'b0;
      sdram_cle  <= 1'b0;
      sdram_a    <= '0;
    end else begin
      sdram_cle <= 1'b1;
      cmd_q     <= sdram_pkg::CMD_NOP;
      dq_oe     <= 1'b0;
      rsp_valid <= 1'b0;
      ref_timer <= ref_due ? ref_timer : ref_timer + 1'b1;
      if (cnt != 0) begin
        cnt <= cnt - 1'b1;
      end
      case (state)
        sdram_pkg::ST_INIT: if (cnt == 0) begin
          cmd_q      <= sdram_pkg::CMD_PRECHARGE;
          sdram_a    <= 13'h0400;
          state      <= sdram_pkg::ST_PRE_ALL;
          cnt        <= 8'(`FB_TRP - 1);
        end
        sdram_pkg::ST_PRE_ALL: if (cnt == 0) begin
          cmd_q     <= sdram_pkg::CMD_REFRESH;
          ref_timer <= '0;
          state     <= sdram_pkg::ST_INIT_REF;
          cnt       <= 8'(`FB_TRFC - 1);
        end
        sdram_pkg::ST_INIT_REF: if (cnt == 0) begin
          if (!second_ref) begin
            cmd_q      <= sdram_pkg::CMD_REFRESH;
            second_ref <= 1'b1;
            cnt        <= 8'(`FB_TRFC - 1);
          end else begin
            cmd_q   <= sdram_pkg::CMD_LOAD_MODE;
            sdram_a <= MODE_REG;
            state   <= sdram_pkg::ST_MODE;
            cnt     <= 8'd1;
          end
        end
        sdram_pkg::ST_MODE: if (cnt == 0) begin
          state <= sdram_pkg::ST_IDLE;
        end
        sdram_pkg::ST_IDLE: begin
          if (ref_due) begin
            cmd_q     <= sdram_pkg::CMD_REFRESH;
            ref_timer <= '0;
            state     <= sdram_pkg::ST_REFRESH;
            cnt       <= 8'(`FB_TRFC - 1);
          end else if (ctrl_req_valid) begin
            req_q   <= ctrl_req;
            cmd_q   <= sdram_pkg::CMD_ACTIVE;
            sdram_a <= ctrl_req.row;
            state   <= sdram_pkg::ST_RCD;
            cnt     <= 8'(`FB_TRCD - 1);
          end
        end
        sdram_pkg::ST_RCD: if (cnt == 0) begin
          // a10 high selects auto-precharge
          cmd_q   <= req_q.wr ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
          sdram_a <= {3'b001, 1'b0, req_q.col};
          dq_oe   <= req_q.wr;
          dq_out  <= req_q.data;
          state   <= sdram_pkg::ST_RW;
        end
        sdram_pkg::ST_RW: begin
          state <= req_q.wr ? sdram_pkg::ST_TRP : sdram_pkg::ST_CAS;
          cnt   <= req_q.wr ? 8'(`FB_TRP - 1) : 8'd1;
        end
        sdram_pkg::ST_CAS: if (cnt == 0) begin
          rsp.data  <= sdram_dq;
          rsp_valid <= 1'b1;
          state     <= sdram_pkg::ST_TRP;
          cnt       <= 8'(`FB_TRP - 1);
        end
        sdram_pkg::ST_TRP, sdram_pkg::ST_REFRESH: if (cnt == 0) begin
          state <= sdram_pkg::ST_IDLE;
        end
        default: state <= sdram_pkg::ST_INIT;
      endcase
    end
  end

  // cycles since the last command that closes a row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gap <= '0;
    end else if (cmd_q == sdram_pkg::CMD_PRECHARGE || cmd_q == sdram_pkg::CMD_REFRESH ||
                 cmd_q == sdram_pkg::CMD_READ || cmd_q == sdram_pkg::CMD_WRITE) begin
      gap <= '0;
    end else if (gap != 8'hff) begin
      gap <= gap + 1'b1;
    end
  end

  a_trp_before_active: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_q == sdram_pkg::CMD_ACTIVE) |-> (gap >= 8'(`FB_TRP)));

endmodule

/* verilog/fb_writer.sv */
`include "fb_defs.svh"

module fb_writer (
  input  logic                clk,
  input  logic                rst_n,
  input  video_pkg::host_wr_t host_wr,
  input  logic                host_wr_valid,
  output logic                host_credit,
  output sdram_pkg::mem_req_t wr_req,
  output logic                wr_req_valid,
  input  logic                wr_credit
);
  logic [21:0] addr;

  // linear pixel address, upper bits row and low 9 bits column
  assign addr = 22'(host_wr.y) * 22'(`FB_H_ACTIVE) + 22'(host_wr.x);

  // no local buffering so the tokens are shared with the host
  assign host_credit = wr_credit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_req_valid <= 1'b0;
    end else begin
      wr_req_valid <= host_wr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (host_wr_valid) begin
      wr_req.wr   <= 1'b1;
      wr_req.row  <= addr[21:9];
      wr_req.col  <= addr[8:0];
      wr_req.data <= {5'b0, host_wr.pix};
    end
  end

endmodule

/* verilog/scanout.sv */
`include "fb_defs.svh"

module scanout (
  input  logic                clk,
  input  logic                rst_n,
  output sdram_pkg::mem_req_t rd_req,
  output logic                rd_req_valid,
  input  logic                rd_credit,
  input  sdram_pkg::mem_rsp_t rsp,
  input  logic                rsp_valid,
  output logic                vga_hs,
  output logic                vga_vs,
  output logic                vga_r,
  output logic                vga_g,
  output logic                vga_b
);
  localparam logic [7:0] H_ACT  = 8'(`FB_H_ACTIVE);
  localparam logic [7:0] HS_BEG = 8'(`FB_H_ACTIVE + `FB_H_FRONT);
  localparam logic [7:0] HS_END = 8'(`FB_H_ACTIVE + `FB_H_FRONT + `FB_H_SYNC);
  localparam logic [7:0] H_TOT  = 8'(`FB_H_ACTIVE + `FB_H_FRONT + `FB_H_SYNC + `FB_H_BACK);
  localparam logic [3:0] V_ACT  = 4'(`FB_V_ACTIVE);
  localparam logic [3:0] VS_BEG = 4'(`FB_V_ACTIVE + `FB_V_FRONT);
  localparam logic [3:0] VS_END = 4'(`FB_V_ACTIVE + `FB_V_FRONT + `FB_V_SYNC);
  localparam logic [3:0] V_TOT  = 4'(`FB_V_ACTIVE + `FB_V_FRONT + `FB_V_SYNC + `FB_V_BACK);

  video_pkg::pixel_t line_buf [2*`FB_H_ACTIVE];
  video_pkg::pixel_t shown;
  logic [7:0] h_cnt;
  logic [3:0] v_cnt;
  logic [2:0] fetch_y;
  logic [3:0] fetch_x;
  logic [3:0] rsp_x;
  logic [1:0] credits;
  logic       fetching;
  logic       rsp_done;
  logic       primed;
  logic       fetch_start;
  logic       issue;
  logic       active;

  // line n+1 is fetched while line n blanks, line 0 in the last vblank line
  assign fetch_start = (h_cnt == H_ACT) && ((v_cnt < V_ACT - 1'b1) || (v_cnt == V_TOT - 1'b1));
  assign issue  = fetching && (credits != 0);
  assign active = (h_cnt < H_ACT) && (v_cnt < V_ACT);
  assign shown  = line_buf[{v_cnt[0], h_cnt[3:0]}];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt        <= '0;
      v_cnt        <= '0;
      vga_hs       <= 1'b1;
      vga_vs       <= 1'b1;
      {vga_r, vga_g, vga_b} <= 3'b000;
      fetching     <= 1'b0;
      fetch_x      <= '0;
      fetch_y      <= '0;
      rsp_x        <= '0;
      rsp_done     <= 1'b0;
      primed       <= 1'b0;
      credits      <= 2'(`FB_CREDITS);
      rd_req_valid <= 1'b0;
    end else begin
      h_cnt <= (h_cnt == H_TOT - 1'b1) ? '0 : h_cnt + 1'b1;
      if (h_cnt == H_TOT - 1'b1) begin
        v_cnt <= (v_cnt == V_TOT - 1'b1) ? '0 : v_cnt + 1'b1;
      end
      vga_hs <= !((h_cnt >= HS_BEG) && (h_cnt < HS_END));
      vga_vs <= !((v_cnt >= VS_BEG) && (v_cnt < VS_END));
      {vga_r, vga_g, vga_b} <= active ? shown : 3'b000;

      if (fetch_start) begin
        fetching <= 1'b1;
        fetch_x  <= '0;
        fetch_y  <= (v_cnt == V_TOT - 1'b1) ? 3'd0 : 3'(v_cnt + 1'b1);
        rsp_x    <= '0;
        rsp_done <= 1'b0;
        primed   <= 1'b1;
      end else if (issue) begin
        fetch_x <= fetch_x + 1'b1;
        if (fetch_x == 4'(`FB_H_ACTIVE - 1)) begin
          fetching <= 1'b0;
        end
      end
      rd_req_valid <= issue;
      credits <= credits - 2'(issue) + 2'(rd_credit);

      if (rsp_valid) begin
        rsp_x <= rsp_x + 1'b1;
        if (rsp_x == 4'(`FB_H_ACTIVE - 1)) begin
          rsp_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_req.wr   <= 1'b0;
      rd_req.row  <= '0;
      rd_req.col  <= 9'({fetch_y, fetch_x});
      rd_req.data <= '0;
    end
    if (rsp_valid) begin
      line_buf[{fetch_y[0], rsp_x}] <= rsp.data[2:0];
    end
  end

  // the whole next line must be back before it is shown
  a_line_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (primed && h_cnt == '0 && v_cnt < V_ACT) |-> rsp_done);

endmodule

/* verilog/mojo_top.sv */
module mojo_top (
  input  logic                clk,
  input  logic                rst_n,
  input  video_pkg::host_wr_t host_wr,
  input  logic                host_wr_valid,
  output logic                host_credit,
  // sdram
  output logic                sdram_clk,
  output logic                sdram_cle,
  output logic                sdram_dqm,
  output logic                sdram_cs,
  output logic                sdram_we,
  output logic                sdram_cas,
  output logic                sdram_ras,
  output logic [1:0]          sdram_ba,
  output logic [12:0]         sdram_a,
  inout  wire  [7:0]          sdram_dq,
  // vga
  output logic                vga_hs,
  output logic                vga_vs,
  output logic                vga_r,
  output logic                vga_g,
  output logic                vga_b
);
  sdram_pkg::mem_req_t wr_req;
  sdram_pkg::mem_req_t rd_req;
  sdram_pkg::mem_req_t ctrl_req;
  sdram_pkg::mem_rsp_t rsp;
  logic wr_req_valid;
  logic wr_credit;
  logic rd_req_valid;
  logic rd_credit;
  logic ctrl_req_valid;
  logic ctrl_ready;
  logic rsp_valid;

  fb_writer i_fb_writer (
    .clk(clk), .rst_n(rst_n), .host_wr(host_wr), .host_wr_valid(host_wr_valid),
    .host_credit(host_credit), .wr_req(wr_req), .wr_req_valid(wr_req_valid),
    .wr_credit(wr_credit)
  );

  scanout i_scanout (
    .clk(clk), .rst_n(rst_n), .rd_req(rd_req), .rd_req_valid(rd_req_valid),
    .rd_credit(rd_credit), .rsp(rsp), .rsp_valid(rsp_valid),
    .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
  );

  sdram_arbiter i_sdram_arbiter (
    .clk(clk), .rst_n(rst_n),
    .wr_req(wr_req), .wr_req_valid(wr_req_valid), .wr_credit(wr_credit),
    .rd_req(rd_req), .rd_req_valid(rd_req_valid), .rd_credit(rd_credit),
    .ctrl_req(ctrl_req), .ctrl_req_valid(ctrl_req_valid), .ctrl_ready(ctrl_ready)
  );

  sdram_ctrl i_sdram_ctrl (
    .clk(clk), .rst_n(rst_n),
    .ctrl_req(ctrl_req), .ctrl_req_valid(ctrl_req_valid), .ctrl_ready(ctrl_ready),
    .rsp(rsp), .rsp_valid(rsp_valid),
    .sdram_clk(sdram_clk), .sdram_cle(sdram_cle), .sdram_dqm(sdram_dqm),
    .sdram_cs(sdram_cs), .sdram_we(sdram_we), .sdram_cas(sdram_cas),
    .sdram_ras(sdram_ras), .sdram_ba(sdram_ba), .sdram_a(sdram_a), .sdram_dq(sdram_dq)
  );

endmodule

/* sim/sdram_model.sv */
module sdram_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cle,
  input  logic        dqm,
  input  logic        cs,
  input  logic        ras,
  input  logic        cas,
  input  logic        we,
  input  logic [1:0]  ba,
  input  logic [12:0] a,
  inout  wire  [7:0]  dq,
  output int          refresh_count,
  output int          cmd_errors
);
  logic [7:0]  mem [1024];
  logic [7:0]  rd_data [2];
  logic [1:0]  rd_pipe;
  logic [12:0] open_row;
  logic        row_open;
  logic        rd_cmd;
  logic [9:0]  addr;
  sdram_pkg::sdram_cmd_e cmd;

  assign cmd    = sdram_pkg::sdram_cmd_e'({cs, ras, cas, we});
  assign addr   = {open_row[0], a[8:0]};
  // dqm read latency is two, so at cas latency 2 it masks at the READ edge
  assign rd_cmd = cle && !dqm && row_open && (ba == 2'b00) && (cmd == sdram_pkg::CMD_READ);

  // cas latency 2, data is on dq for the second edge after READ
  assign dq = rd_pipe[1] ? rd_data[1] : 8'bz;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      refresh_count <= 0;
      cmd_errors    <= 0;
      row_open      <= 1'b0;
      rd_pipe       <= '0;
    end else begin
      rd_pipe    <= {rd_pipe[0], rd_cmd};
      rd_data[1] <= rd_data[0];
      if (cle) begin
        case (cmd)
          sdram_pkg::CMD_ACTIVE: begin
            row_open <= 1'b1;
            open_row <= a;
          end
          sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
            // only bank 0 holds an open row
            if (!row_open || ba != 2'b00) begin
              $display("sdram model: %s in bank %0d at column %0d with no open row",
                       cmd.name(), ba, a[8:0]);
              cmd_errors <= cmd_errors + 1;
            end else if (cmd == sdram_pkg::CMD_WRITE) begin
              if (!dqm) begin
                mem[addr] <= dq;
              end
            end else begin
              rd_data[0] <= mem[addr];
            end
            // a10 closes the row after the access
            if (a[10]) begin
              row_open <= 1'b0;
            end
          end
          sdram_pkg::CMD_PRECHARGE: row_open <= 1'b0;
          sdram_pkg::CMD_REFRESH: begin
            row_open      <= 1'b0;
            refresh_count <= refresh_count + 1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* sim/tb_mojo_top.sv */
`include "fb_defs.svh"

module tb_mojo_top;
  localparam int H_ACT = `FB_H_ACTIVE;
  localparam int V_ACT = `FB_V_ACTIVE;
  localparam int H_TOT = `FB_H_ACTIVE + `FB_H_FRONT + `FB_H_SYNC + `FB_H_BACK;
  localparam int V_TOT = `FB_V_ACTIVE + `FB_V_FRONT + `FB_V_SYNC + `FB_V_BACK;
  localparam int FRAME = H_TOT * V_TOT;
  localparam int N_RAND = 8;
  localparam int N_WR = 12 + N_RAND;
  // a write can wait out one line fetch, then up to a frame to vsync and one to check
  localparam int TIMEOUT_CYCLES = `FB_INIT_WAIT + 12 + N_WR * H_TOT + 3 * FRAME;

  logic clk;
  logic rst_n;
  video_pkg::host_wr_t host_wr;
  logic host_wr_valid;
  logic host_credit;
  logic sdram_clk;
  logic sdram_cle;
  logic sdram_dqm;
  logic sdram_cs;
  logic sdram_we;
  logic sdram_cas;
  logic sdram_ras;
  logic [1:0] sdram_ba;
  logic [12:0] sdram_a;
  wire [7:0] sdram_dq;
  logic vga_hs;
  logic vga_vs;
  logic vga_r;
  logic vga_g;
  logic vga_b;
  int refresh_count;
  int cmd_errors;

  video_pkg::host_wr_t writes [$];
  logic [2:0] expected [H_ACT * V_ACT];
  logic [15:0] lfsr;
  int value_errors = 0;
  int other_errors = 0;
  int sent = 0;
  int credit_cnt = 0;
  int cycles = 0;
  int hcount = 0;
  int hs_num = -1;
  int hs_in_frame = 0;
  int pixels_checked = 0;
  logic hs_q;
  logic vs_q;
  logic hs_seen = 1'b0;
  logic vs_seen = 1'b0;
  logic after_reset = 1'b0;
  logic armed = 1'b0;
  logic checking = 1'b0;
  logic frame_done = 1'b0;

  mojo_top i_dut (
    .clk(clk), .rst_n(rst_n), .host_wr(host_wr), .host_wr_valid(host_wr_valid),
    .host_credit(host_credit),
    .sdram_clk(sdram_clk), .sdram_cle(sdram_cle), .sdram_dqm(sdram_dqm),
    .sdram_cs(sdram_cs), .sdram_we(sdram_we), .sdram_cas(sdram_cas),
    .sdram_ras(sdram_ras), .sdram_ba(sdram_ba), .sdram_a(sdram_a), .sdram_dq(sdram_dq),
    .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
  );

  sdram_model i_sdram (
    .clk(sdram_clk), .rst_n(rst_n), .cle(sdram_cle), .dqm(sdram_dqm), .cs(sdram_cs),
    .ras(sdram_ras), .cas(sdram_cas), .we(sdram_we), .ba(sdram_ba), .a(sdram_a),
    .dq(sdram_dq), .refresh_count(refresh_count), .cmd_errors(cmd_errors)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      value_errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, exp_val, act_val);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // galois form, taps for a maximal 16-bit sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [9:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[8:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_write(input logic [3:0] x, input logic [2:0] y, input logic [2:0] pix);
    writes.push_back(video_pkg::host_wr_t'({x, y, pix}));
  endtask

  always @(negedge clk) begin
    logic hs_fall;
    logic vs_fall;
    int line;
    int px;
    hs_fall = hs_q && !vga_hs;
    vs_fall = vs_q && !vga_vs;
    hs_q = vga_hs;
    vs_q = vga_vs;

    // syncs idle high and black through reset and the cycle after
    if (!rst_n) begin
      check_value("reset outputs", 32'(5'b11000), 32'({vga_hs, vga_vs, vga_r, vga_g, vga_b}));
      after_reset = 1'b1;
    end else if (after_reset) begin
      check_value("outputs after reset", 32'(5'b11000),
                  32'({vga_hs, vga_vs, vga_r, vga_g, vga_b}));
      after_reset = 1'b0;
    end

    if (host_credit === 1'b1) begin
      credit_cnt++;
    end
    if (credit_cnt > sent) begin
      other_errors++;
      $display("credit returned with no write outstanding at cycle %0d", cycles);
    end
    if (sent == N_WR && credit_cnt == sent) begin
      armed = 1'b1;
    end

    if (hs_fall) begin
      if (hs_seen) begin
        check_value("hsync period", H_TOT, hcount + 1);
      end
      hs_seen = 1'b1;
      hcount = 0;
      hs_num++;
      hs_in_frame++;
    end else begin
      hcount++;
    end
    if (vs_fall) begin
      if (vs_seen) begin
        check_value("hsync pulses per frame", V_TOT, hs_in_frame);
      end
      vs_seen = 1'b1;
      hs_in_frame = 0;
      hs_num = -1;
      if (armed && !checking && !frame_done) begin
        checking = 1'b1;
      end
    end

    // the pixels after an hsync belong to the next line
    if (checking) begin
      line = hs_num - (`FB_V_SYNC + `FB_V_BACK - 1);
      px = hcount - (`FB_H_SYNC + `FB_H_BACK);
      if (line >= 0 && line < V_ACT && px >= 0 && px < H_ACT) begin
        check_value($sformatf("pixel (%0d,%0d)", px, line), 32'(expected[line * H_ACT + px]),
                    32'({vga_r, vga_g, vga_b}));
        pixels_checked++;
        if (line == V_ACT - 1 && px == H_ACT - 1) begin
          checking = 1'b0;
          frame_done = 1'b1;
        end
      end
    end
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    $display("timeout: frame check not finished after %0d cycles", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    logic [9:0] bits;
    int min_refresh;
    clk = 1'b0;
    rst_n = 1'b0;
    host_wr = '0;
    host_wr_valid = 1'b0;
    hs_q = 1'b1;
    vs_q = 1'b1;
    lfsr = 16'd61;

    // corners, a run on line 3, and one overwrite
    add_write(4'd0, 3'd0, 3'b100);
    add_write(4'd15, 3'd0, 3'b010);
    add_write(4'd0, 3'd7, 3'b001);
    add_write(4'd15, 3'd7, 3'b111);
    add_write(4'd5, 3'd3, 3'b110);
    add_write(4'd6, 3'd3, 3'b011);
    add_write(4'd7, 3'd3, 3'b101);
    add_write(4'd8, 3'd4, 3'b111);
    add_write(4'd1, 3'd1, 3'b001);
    add_write(4'd14, 3'd6, 3'b010);
    add_write(4'd5, 3'd3, 3'b001);
    add_write(4'd9, 3'd2, 3'b100);
    for (int i = 0; i < N_RAND; i++) begin
      draw_bits(10, bits);
      writes.push_back(video_pkg::host_wr_t'(bits));
    end
    for (int i = 0; i < H_ACT * V_ACT; i++) begin
      expected[i] = '0;
    end
    foreach (writes[i]) begin
      expected[int'(writes[i].y) * H_ACT + int'(writes[i].x)] = writes[i].pix;
    end

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    foreach (writes[i]) begin
      while (sent - credit_cnt >= `FB_CREDITS) begin
        next_cycle();
      end
      host_wr = writes[i];
      host_wr_valid = 1'b1;
      sent++;
      next_cycle();
      host_wr_valid = 1'b0;
    end

    wait (frame_done);
    check_value("host credits", N_WR, credit_cnt);
    check_value("pixels checked", H_ACT * V_ACT, pixels_checked);
    min_refresh = cycles / `FB_REFRESH_INTERVAL - 1;
    if (refresh_count < min_refresh) begin
      other_errors++;
      $display("only %0d refreshes in %0d cycles, expected at least %0d",
               refresh_count, cycles, min_refresh);
    end
    if (cmd_errors != 0) begin
      other_errors++;
      $display("sdram model saw %0d accesses without an open row", cmd_errors);
    end
    $display("tb_mojo_top: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
verilog/sdram_pkg.sv
verilog/video_pkg.sv
verilog/sdram_arbiter.sv
verilog/sdram_ctrl.sv
verilog/fb_writer.sv
verilog/scanout.sv
verilog/mojo_top.sv
sim/sdram_model.sv
sim/tb_mojo_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mojo_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
